// File: logic/uart_axil_regs.sv
`timescale 1ns/1ns
`include "uart_defs.svh"

module uart_axil_regs (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [`UART_AXI_AW-1:0]    awaddr,
	input  logic                       awvalid,
	output logic                       awready,
	input  logic [`UART_AXI_DW-1:0]    wdata,
	input  logic [`UART_AXI_DW/8-1:0]  wstrb,
	input  logic                       wvalid,
	output logic                       wready,
	output logic [1:0]                 bresp,
	output logic                       bvalid,
	input  logic                       bready,
	input  logic [`UART_AXI_AW-1:0]    araddr,
	input  logic                       arvalid,
	output logic                       arready,
	output logic [`UART_AXI_DW-1:0]    rdata,
	output logic [1:0]                 rresp,
	output logic                       rvalid,
	input  logic                       rready,
	output uart_pkg::uart_cfg_t        cfg,
	output logic                       tx_start,
	output logic [7:0]                 tx_byte,
	input  logic                       tx_busy,
	input  uart_pkg::uart_rx_evt_t     rx_evt
);
	localparam logic [1:0] RESP_OKAY = 2'b00;

	logic                    wr_accept;
	logic                    rd_accept;
	logic                    wr_ctrl;
	logic                    wr_baud;
	logic                    wr_txdata;
	logic                    rd_status;
	logic                    rd_rxdata;
	logic                    rx_valid;
	logic                    parity_err;
	logic                    overrun;
	logic [7:0]              rx_byte;
	logic [`UART_AXI_DW-1:0] rd_word;

	// a pending response blocks the next request on that channel
	assign wr_accept = awvalid & wvalid & ~bvalid;
	assign rd_accept = arvalid & ~rvalid;
	assign awready = wr_accept;
	assign wready = wr_accept;
	assign arready = rd_accept;
	assign bresp = RESP_OKAY;
	assign rresp = RESP_OKAY;

	assign wr_ctrl = wr_accept && (awaddr == `UART_ADDR_CTRL) && wstrb[0];
	assign wr_baud = wr_accept && (awaddr == `UART_ADDR_BAUD);
	assign wr_txdata = wr_accept && (awaddr == `UART_ADDR_TXDATA) && wstrb[0];
	assign rd_status = rd_accept && (araddr == `UART_ADDR_STATUS);
	assign rd_rxdata = rd_accept && (araddr == `UART_ADDR_RXDATA);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (wr_accept) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			if (rd_accept) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// configuration registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg <= '0;
		end else begin
			if (wr_ctrl) begin
				cfg.rx_en <= wdata[0];
				cfg.tx_en <= wdata[1];
				cfg.no_parity <= wdata[2];
				cfg.ev_parity <= wdata[3];
			end
			if (wr_baud && wstrb[0]) begin
				cfg.baud_div[7:0] <= wdata[7:0];
			end
			if (wr_baud && wstrb[1]) begin
				cfg.baud_div[15:8] <= wdata[15:8];
			end
		end
	end

	// a write while the transmitter is busy is acked and lost
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_start <= 1'b0;
		end else begin
			tx_start <= wr_txdata && !tx_busy;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_txdata && !tx_busy) begin
			tx_byte <= wdata[7:0];
		end
	end

	// receive holding byte and sticky flags
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_byte <= `UART_DATA_REG_DFT;
			rx_valid <= 1'b0;
			parity_err <= 1'b0;
			overrun <= 1'b0;
		end else begin
			if (rx_evt.rx_ok) begin
				rx_byte <= rx_evt.data;
				rx_valid <= 1'b1;
			end else if (rd_rxdata) begin
				rx_valid <= 1'b0;
			end
			// the old byte is lost unless it is being read right now
			if (rx_evt.rx_ok && rx_valid && !rd_rxdata) begin
				overrun <= 1'b1;
			end else if (rd_status) begin
				overrun <= 1'b0;
			end
			if (rx_evt.parity_error) begin
				parity_err <= 1'b1;
			end else if (rd_status) begin
				parity_err <= 1'b0;
			end
		end
	end

	always_comb begin
		rd_word = '0;
		case (araddr)
			`UART_ADDR_CTRL: rd_word[3:0] = {cfg.ev_parity, cfg.no_parity, cfg.tx_en, cfg.rx_en};
			`UART_ADDR_BAUD: rd_word[15:0] = cfg.baud_div;
			`UART_ADDR_STATUS: rd_word[3:0] = {tx_busy, overrun, parity_err, rx_valid};
			`UART_ADDR_RXDATA: rd_word[7:0] = rx_byte;
			default: rd_word = '0;
		endcase
	end

	// read data is sampled at acceptance and held with rvalid
	always_ff @(posedge clk) begin
		if (rd_accept) begin
			rdata <= rd_word;
		end
	end

endmodule

// File: logic/uart_baud_gen.sv
`timescale 1ns/1ns

module uart_baud_gen (
	input  logic                clk,
	input  logic                rst_n,
	input  uart_pkg::uart_cfg_t cfg,
	output logic                sample_tick
);
	logic [15:0] div_cnt;
	logic        uart_on;

	// the tick only runs while one direction is enabled
	assign uart_on = cfg.rx_en | cfg.tx_en;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			sample_tick <= 1'b0;
		end else if (!uart_on) begin
			div_cnt <= cfg.baud_div;
			sample_tick <= 1'b0;
		end else if (div_cnt == '0) begin
			div_cnt <= cfg.baud_div;
			sample_tick <= 1'b1;
		end else begin
			div_cnt <= div_cnt - 16'd1;
			sample_tick <= 1'b0;
		end
	end

endmodule

// File: logic/uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// register byte offsets
`define UART_ADDR_CTRL     5'h00
`define UART_ADDR_BAUD     5'h04
`define UART_ADDR_STATUS   5'h08
`define UART_ADDR_TXDATA   5'h0c
`define UART_ADDR_RXDATA   5'h10

// receive data value after reset or while the receiver is off
`define UART_DATA_REG_DFT  8'hff

// sample ticks per bit
`define UART_OVERSAMPLE    16

// axi4-lite bus widths
`define UART_AXI_AW        5
`define UART_AXI_DW        32

`endif

// File: logic/uart_pkg.sv
package uart_pkg;

	// configuration as held by the register block
	typedef struct packed {
		logic        rx_en;
		logic        tx_en;
		// parity bit left out of the frame
		logic        no_parity;
		// 1 for even parity, 0 for odd
		logic        ev_parity;
		// sample tick period is baud_div+1 clocks
		logic [15:0] baud_div;
	} uart_cfg_t;

	// receiver events towards the register block
	typedef struct packed {
		// one-cycle pulses
		logic       rx_ok;
		logic       parity_error;
		// last received byte
		logic [7:0] data;
	} uart_rx_evt_t;

endpackage

// File: logic/uart_rx.sv
`timescale 1ns/1ns
`include "uart_defs.svh"

module uart_rx (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   sample_tick,
	input  uart_pkg::uart_cfg_t    cfg,
	input  logic                   rxd,
	output uart_pkg::uart_rx_evt_t rx_evt
);
	localparam logic [1:0] RX_IDLE   = 2'd0;
	localparam logic [1:0] RX_DATA   = 2'd1;
	localparam logic [1:0] RX_PARITY = 2'd2;
	localparam logic [1:0] RX_STOP   = 2'd3;

	localparam logic [3:0] LAST_SAMPLE = 4'(`UART_OVERSAMPLE - 1);
	// vote samples around the middle of the bit
	localparam logic [3:0] SMP_A      = 4'd7;
	localparam logic [3:0] SMP_B      = 4'd8;
	localparam logic [3:0] SMP_C      = 4'd9;
	localparam logic [3:0] SMP_VOTE   = 4'd10;
	localparam logic [3:0] STOP_CHECK = 4'd11;
	localparam logic [3:0] STOP_DONE  = 4'd12;

	logic [1:0] state;
	logic [2:0] bit_cnt;
	logic [3:0] sample_cnt;
	logic [7:0] data_r;
	logic       smp_a;
	logic       smp_b;
	logic       smp_c;
	logic       vote;
	logic       rx_pos;
	logic       parity_exp;
	logic       parity_bad;

	assign rx_pos = cfg.rx_en & sample_tick;

	// even parity is the xor of the data, odd its inverse
	assign parity_exp = ^data_r ^ ~cfg.ev_parity;
	assign parity_bad = (vote != parity_exp);

	assign rx_evt.rx_ok = rx_pos && (state == RX_STOP) && (sample_cnt == STOP_DONE);
	assign rx_evt.parity_error = rx_pos && (state == RX_PARITY) &&
		(sample_cnt == LAST_SAMPLE) && parity_bad;
	assign rx_evt.data = data_r;

	// three samples and a majority vote per bit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			smp_a <= 1'b1;
			smp_b <= 1'b1;
			smp_c <= 1'b1;
			vote <= 1'b1;
		end else if (rx_pos) begin
			case (sample_cnt)
				SMP_A: smp_a <= rxd;
				SMP_B: smp_b <= rxd;
				SMP_C: smp_c <= rxd;
				SMP_VOTE: vote <= (smp_a & smp_b) | (smp_a & smp_c) | (smp_b & smp_c);
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= RX_IDLE;
			bit_cnt <= '0;
			sample_cnt <= '0;
			data_r <= `UART_DATA_REG_DFT;
		end else if (!cfg.rx_en) begin
			state <= RX_IDLE;
			bit_cnt <= '0;
			sample_cnt <= '0;
			data_r <= `UART_DATA_REG_DFT;
		end else if (rx_pos) begin
			case (state)
				RX_IDLE: begin
					// line must stay low for a whole bit to count as a start
					if (sample_cnt == LAST_SAMPLE) begin
						sample_cnt <= '0;
						bit_cnt <= '0;
						state <= RX_DATA;
					end else if (rxd) begin
						sample_cnt <= '0;
					end else begin
						sample_cnt <= sample_cnt + 4'd1;
					end
				end
				RX_DATA: begin
					if (sample_cnt == LAST_SAMPLE) begin
						sample_cnt <= '0;
						// lsb first, so shift in from the top
						data_r <= {vote, data_r[7:1]};
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) begin
							state <= cfg.no_parity ? RX_STOP : RX_PARITY;
						end
					end else begin
						sample_cnt <= sample_cnt + 4'd1;
					end
				end
				RX_PARITY: begin
					if (sample_cnt == LAST_SAMPLE) begin
						sample_cnt <= '0;
						// a bad parity drops the frame
						state <= parity_bad ? RX_IDLE : RX_STOP;
					end else begin
						sample_cnt <= sample_cnt + 4'd1;
					end
				end
				RX_STOP: begin
					if (sample_cnt == STOP_DONE) begin
						sample_cnt <= '0;
						state <= RX_IDLE;
					end else if (!rxd) begin
						// still low, wait for the stop level again
						sample_cnt <= '0;
					end else if ((sample_cnt == STOP_CHECK) && !vote) begin
						sample_cnt <= '0;
					end else begin
						sample_cnt <= sample_cnt + 4'd1;
					end
				end
				default: begin
					state <= RX_IDLE;
					sample_cnt <= '0;
				end
			endcase
		end
	end

endmodule

// File: logic/uart_top.sv
`timescale 1ns/1ns
`include "uart_defs.svh"

module uart_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [`UART_AXI_AW-1:0]    awaddr,
	input  logic                       awvalid,
	output logic                       awready,
	input  logic [`UART_AXI_DW-1:0]    wdata,
	input  logic [`UART_AXI_DW/8-1:0]  wstrb,
	input  logic                       wvalid,
	output logic                       wready,
	output logic [1:0]                 bresp,
	output logic                       bvalid,
	input  logic                       bready,
	input  logic [`UART_AXI_AW-1:0]    araddr,
	input  logic                       arvalid,
	output logic                       arready,
	output logic [`UART_AXI_DW-1:0]    rdata,
	output logic [1:0]                 rresp,
	output logic                       rvalid,
	input  logic                       rready,
	input  logic                       rxd,
	output logic                       txd
);
	import uart_pkg::*;

	uart_cfg_t    cfg;
	uart_rx_evt_t rx_evt;
	logic         sample_tick;
	logic         tx_start;
	logic [7:0]   tx_byte;
	logic         tx_busy;

	uart_axil_regs u_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.awaddr   (awaddr),
		.awvalid  (awvalid),
		.awready  (awready),
		.wdata    (wdata),
		.wstrb    (wstrb),
		.wvalid   (wvalid),
		.wready   (wready),
		.bresp    (bresp),
		.bvalid   (bvalid),
		.bready   (bready),
		.araddr   (araddr),
		.arvalid  (arvalid),
		.arready  (arready),
		.rdata    (rdata),
		.rresp    (rresp),
		.rvalid   (rvalid),
		.rready   (rready),
		.cfg      (cfg),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.tx_busy  (tx_busy),
		.rx_evt   (rx_evt)
	);

	// one sample tick shared by both directions
	uart_baud_gen u_baud_gen (
		.clk         (clk),
		.rst_n       (rst_n),
		.cfg         (cfg),
		.sample_tick (sample_tick)
	);

	uart_rx u_rx (
		.clk         (clk),
		.rst_n       (rst_n),
		.sample_tick (sample_tick),
		.cfg         (cfg),
		.rxd         (rxd),
		.rx_evt      (rx_evt)
	);

	uart_tx u_tx (
		.clk         (clk),
		.rst_n       (rst_n),
		.sample_tick (sample_tick),
		.cfg         (cfg),
		.tx_start    (tx_start),
		.tx_byte     (tx_byte),
		.txd         (txd),
		.tx_busy     (tx_busy)
	);

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/1ns
`include "uart_defs.svh"

module uart_tx (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                sample_tick,
	input  uart_pkg::uart_cfg_t cfg,
	input  logic                tx_start,
	input  logic [7:0]          tx_byte,
	output logic                txd,
	output logic                tx_busy
);
	localparam logic [2:0] TX_IDLE   = 3'd0;
	localparam logic [2:0] TX_START  = 3'd1;
	localparam logic [2:0] TX_DATA   = 3'd2;
	localparam logic [2:0] TX_PARITY = 3'd3;
	localparam logic [2:0] TX_STOP   = 3'd4;

	localparam logic [3:0] LAST_SAMPLE = 4'(`UART_OVERSAMPLE - 1);

	logic [2:0] state;
	logic [3:0] sample_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] shift_reg;
	logic       parity_bit;
	logic       bit_end;

	assign tx_busy = (state != TX_IDLE);
	assign bit_end = sample_tick && (sample_cnt == LAST_SAMPLE);

	// byte and parity are captured when the frame is accepted
	always_ff @(posedge clk) begin
		if ((state == TX_IDLE) && tx_start) begin
			shift_reg <= tx_byte;
			parity_bit <= ^tx_byte ^ ~cfg.ev_parity;
		end else if ((state == TX_DATA) && bit_end) begin
			shift_reg <= shift_reg >> 1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= TX_IDLE;
			sample_cnt <= '0;
			bit_cnt <= '0;
			txd <= 1'b1;
		end else if (!cfg.tx_en) begin
			state <= TX_IDLE;
			sample_cnt <= '0;
			bit_cnt <= '0;
			txd <= 1'b1;
		end else begin
			case (state)
				TX_IDLE: begin
					if (tx_start) begin
						state <= TX_START;
						sample_cnt <= '0;
						bit_cnt <= '0;
					end
				end
				TX_START: begin
					// line still high means the start bit has not gone out yet
					if (sample_tick && txd) begin
						txd <= 1'b0;
					end else if (bit_end) begin
						sample_cnt <= '0;
						txd <= shift_reg[0];
						state <= TX_DATA;
					end else if (sample_tick) begin
						sample_cnt <= sample_cnt + 4'd1;
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						sample_cnt <= '0;
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt != 3'd7) begin
							txd <= shift_reg[1];
						end else if (cfg.no_parity) begin
							txd <= 1'b1;
							state <= TX_STOP;
						end else begin
							txd <= parity_bit;
							state <= TX_PARITY;
						end
					end else if (sample_tick) begin
						sample_cnt <= sample_cnt + 4'd1;
					end
				end
				TX_PARITY: begin
					if (bit_end) begin
						sample_cnt <= '0;
						txd <= 1'b1;
						state <= TX_STOP;
					end else if (sample_tick) begin
						sample_cnt <= sample_cnt + 4'd1;
					end
				end
				TX_STOP: begin
					if (bit_end) begin
						sample_cnt <= '0;
						state <= TX_IDLE;
					end else if (sample_tick) begin
						sample_cnt <= sample_cnt + 4'd1;
					end
				end
				default: begin
					state <= TX_IDLE;
					txd <= 1'b1;
				end
			endcase
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the UART testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -f verilog.f --top-module uart_tb -o uart_tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/uart_tb_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation did not pass"
exit 1

// File: testbench/uart_checker.sv
`timescale 1ns/1ns
`include "uart_defs.svh"

module uart_checker (
	input logic                    clk,
	input logic                    rst_n,
	input logic                    txd,
	input logic                    tx_busy,
	input logic                    tx_start,
	input logic                    bvalid,
	input logic                    bready,
	input logic                    rvalid,
	input logic                    rready,
	input logic [`UART_AXI_DW-1:0] rdata
);
	// number of assertion failures so far
	int fail_count = 0;

	// the line idles high between frames
	idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
		!tx_busy |-> txd)
		else begin
			$error("txd low while tx_busy is clear");
			fail_count++;
		end

	write_resp_held: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid)
		else begin
			$error("bvalid dropped before bready");
			fail_count++;
		end

	read_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> $stable(rdata))
		else begin
			$error("rdata changed while rvalid waited for rready");
			fail_count++;
		end

	// a start request only ever reaches an idle transmitter
	start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		tx_start |-> !tx_busy)
		else begin
			$error("tx_start issued while tx_busy is high");
			fail_count++;
		end

endmodule

bind uart_top uart_checker u_checker (
	.clk      (clk),
	.rst_n    (rst_n),
	.txd      (txd),
	.tx_busy  (tx_busy),
	.tx_start (tx_start),
	.bvalid   (bvalid),
	.bready   (bready),
	.rvalid   (rvalid),
	.rready   (rready),
	.rdata    (rdata)
);

// File: testbench/uart_tb.sv
`timescale 1ns/1ns
`include "uart_defs.svh"

module uart_tb;
	localparam int CLK_PERIOD = 8;
	localparam int BAUD_DIV = 1;
	// sixteen sample ticks per bit
	localparam int BIT_CLKS = 16 * (BAUD_DIV + 1);
	localparam int LOOP_BYTES = 8;
	// plain loopback, two parity runs, injected frame, overrun pair, receiver off
	localparam int FRAME_BITS = LOOP_BYTES * 10 + 2 * LOOP_BYTES * 11 + 11 + 2 * 10 + 10;
	localparam int WATCHDOG_NS = 2 * FRAME_BITS * BIT_CLKS * CLK_PERIOD;
	// one status read takes more than four clocks
	localparam int POLL_LIMIT = 2 * 11 * BIT_CLKS / 4;
	localparam int HANDSHAKE_LIMIT = 16;

	// rx_en, tx_en, no_parity and ev_parity in bits 0 to 3
	localparam logic [31:0] CTRL_NO_PAR = 32'h7;
	localparam logic [31:0] CTRL_EVEN = 32'hb;
	localparam logic [31:0] CTRL_ODD = 32'h3;
	localparam logic [31:0] CTRL_TX_ONLY = 32'h6;
	localparam logic [31:0] ST_RX_VALID = 32'h1;
	localparam logic [31:0] ST_PARITY = 32'h2;
	localparam logic [31:0] ST_OVERRUN = 32'h4;
	localparam logic [31:0] ST_TX_BUSY = 32'h8;

	logic                      clk;
	logic                      rst_n;
	logic [`UART_AXI_AW-1:0]   awaddr;
	logic                      awvalid;
	logic                      awready;
	logic [`UART_AXI_DW-1:0]   wdata;
	logic [`UART_AXI_DW/8-1:0] wstrb;
	logic                      wvalid;
	logic                      wready;
	logic [1:0]                bresp;
	logic                      bvalid;
	logic                      bready;
	logic [`UART_AXI_AW-1:0]   araddr;
	logic                      arvalid;
	logic                      arready;
	logic [`UART_AXI_DW-1:0]   rdata;
	logic [1:0]                rresp;
	logic                      rvalid;
	logic                      rready;
	logic                      rxd;
	logic                      txd;
	logic                      inject;
	logic                      inj_bit;
	logic [31:0]               rng_state;
	int                        errors;
	int                        tests_run;
	int                        tests_failed;

	// serial loopback unless a frame is being bit-banged
	assign rxd = inject ? inj_bit : txd;

	uart_top u_uart_top (
		.clk     (clk),
		.rst_n   (rst_n),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.rxd     (rxd),
		.txd     (txd)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [7:0] next_byte();
		rng_state = xorshift32(rng_state);
		return rng_state[7:0];
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Error: %s expected 0x%0h got 0x%0h", name, exp, got);
		errors++;
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: FAILED with %0d errors", name, errors - err_before);
		end
	endtask

	task automatic axil_write(input logic [`UART_AXI_AW-1:0] addr, input logic [31:0] data);
		int waited;
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		wstrb = 4'hf;
		awvalid = 1'b1;
		wvalid = 1'b1;
		waited = 0;
		// with no response pending the request is taken at once
		#(CLK_PERIOD / 4);
		if (awready != 1'b1) begin
			report_mismatch("awready", {31'h0, awready}, 32'h1);
		end
		if (wready != 1'b1) begin
			report_mismatch("wready", {31'h0, wready}, 32'h1);
		end
		@(negedge clk);
		while (!bvalid && waited < HANDSHAKE_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		// a pending response blocks the next write
		if (bvalid && awready) begin
			report_mismatch("awready", {31'h0, awready}, 32'h0);
		end
		if (bvalid && wready) begin
			report_mismatch("wready", {31'h0, wready}, 32'h0);
		end
		awvalid = 1'b0;
		wvalid = 1'b0;
		if (!bvalid) begin
			$display("write to offset 0x%0h got no response", addr);
			errors++;
		end else begin
			if (bresp != 2'b00) begin
				report_mismatch("bresp", {30'h0, bresp}, 32'h0);
			end
			// response held back for a few cycles
			repeat (3) @(negedge clk);
			bready = 1'b1;
			@(negedge clk);
			bready = 1'b0;
		end
	endtask

	task automatic axil_read(input logic [`UART_AXI_AW-1:0] addr, output logic [31:0] data);
		int waited;
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		waited = 0;
		data = '0;
		// with no response pending the request is taken at once
		#(CLK_PERIOD / 4);
		if (arready != 1'b1) begin
			report_mismatch("arready", {31'h0, arready}, 32'h1);
		end
		@(negedge clk);
		while (!rvalid && waited < HANDSHAKE_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		// a pending response blocks the next read
		if (rvalid && arready) begin
			report_mismatch("arready", {31'h0, arready}, 32'h0);
		end
		arvalid = 1'b0;
		if (!rvalid) begin
			$display("read of offset 0x%0h got no response", addr);
			errors++;
		end else begin
			data = rdata;
			if (rresp != 2'b00) begin
				report_mismatch("rresp", {30'h0, rresp}, 32'h0);
			end
			repeat (2) @(negedge clk);
			rready = 1'b1;
			@(negedge clk);
			rready = 1'b0;
		end
	endtask

	// polls STATUS until the masked bits match
	// seen is the OR of every status word read on the way
	task automatic wait_status(input logic [31:0] mask, input logic [31:0] want,
		input string what, output logic [31:0] status, output logic [31:0] seen,
		output bit ok);
		int polls;
		polls = 0;
		ok = 1'b0;
		seen = '0;
		status = '0;
		while (!ok && polls < POLL_LIMIT) begin
			axil_read(`UART_ADDR_STATUS, status);
			seen = seen | status;
			polls++;
			if ((status & mask) == want) begin
				ok = 1'b1;
			end
		end
		if (!ok) begin
			$display("timed out waiting for %s", what);
			errors++;
		end
	endtask

	task automatic send_bit(input logic value);
		inj_bit = value;
		repeat (BIT_CLKS) @(negedge clk);
	endtask

	task automatic inject_frame(input logic [7:0] data, input logic par_bit);
		int i;
		@(negedge clk);
		inject = 1'b1;
		send_bit(1'b0);
		for (i = 0; i < 8; i++) begin
			send_bit(data[i]);
		end
		send_bit(par_bit);
		send_bit(1'b1);
		inject = 1'b0;
	endtask

	task automatic reset_values_test();
		int err_before;
		logic [31:0] rd;
		err_before = errors;
		if (txd != 1'b1) begin
			report_mismatch("txd", {31'h0, txd}, 32'h1);
		end
		if (bvalid != 1'b0) begin
			report_mismatch("bvalid", {31'h0, bvalid}, 32'h0);
		end
		if (rvalid != 1'b0) begin
			report_mismatch("rvalid", {31'h0, rvalid}, 32'h0);
		end
		axil_read(`UART_ADDR_CTRL, rd);
		if (rd != 32'h0) begin
			report_mismatch("rdata (CTRL)", rd, 32'h0);
		end
		axil_read(`UART_ADDR_BAUD, rd);
		if (rd != 32'h0) begin
			report_mismatch("rdata (BAUD)", rd, 32'h0);
		end
		axil_read(`UART_ADDR_STATUS, rd);
		if (rd != 32'h0) begin
			report_mismatch("rdata (STATUS)", rd, 32'h0);
		end
		axil_read(`UART_ADDR_RXDATA, rd);
		if (rd != 32'h0000_00ff) begin
			report_mismatch("rdata (RXDATA)", rd, 32'h0000_00ff);
		end
		finish_test("reset values", err_before);
	endtask

	task automatic loopback_test(input string name, input logic [31:0] ctrl);
		int err_before;
		int i;
		logic [7:0] tx_val;
		logic [31:0] st;
		logic [31:0] seen;
		logic [31:0] flags;
		logic [31:0] rd;
		bit ok;
		err_before = errors;
		flags = '0;
		axil_write(`UART_ADDR_BAUD, 32'(BAUD_DIV));
		axil_write(`UART_ADDR_CTRL, ctrl);
		for (i = 0; i < LOOP_BYTES; i++) begin
			tx_val = next_byte();
			wait_status(ST_TX_BUSY, 32'h0, "transmitter idle", st, seen, ok);
			flags = flags | seen;
			axil_write(`UART_ADDR_TXDATA, {24'h0, tx_val});
			// a second byte while the frame is on the line is dropped
			axil_write(`UART_ADDR_TXDATA, {24'h0, ~tx_val});
			wait_status(ST_RX_VALID, ST_RX_VALID, "rx_valid", st, seen, ok);
			flags = flags | seen;
			if (ok) begin
				axil_read(`UART_ADDR_RXDATA, rd);
				if (rd != {24'h0, tx_val}) begin
					report_mismatch("rdata (RXDATA)", rd, {24'h0, tx_val});
				end
				axil_read(`UART_ADDR_STATUS, rd);
				flags = flags | rd;
				if (rd[0] != 1'b0) begin
					report_mismatch("rx_valid (STATUS)", {31'h0, rd[0]}, 32'h0);
				end
			end
		end
		if (flags[1] != 1'b0) begin
			report_mismatch("parity_err (STATUS)", {31'h0, flags[1]}, 32'h0);
		end
		finish_test(name, err_before);
	endtask

	task automatic parity_error_test();
		int err_before;
		logic [7:0] tx_val;
		logic [31:0] st;
		logic [31:0] seen;
		logic [31:0] rd;
		bit ok;
		err_before = errors;
		wait_status(ST_TX_BUSY, 32'h0, "transmitter idle", st, seen, ok);
		axil_write(`UART_ADDR_CTRL, CTRL_EVEN);
		tx_val = next_byte();
		// even parity bit is the xor of the data, so send its inverse
		inject_frame(tx_val, ~(^tx_val));
		wait_status(ST_PARITY, ST_PARITY, "parity_err", st, seen, ok);
		if (ok && st[0] != 1'b0) begin
			report_mismatch("rx_valid (STATUS)", {31'h0, st[0]}, 32'h0);
		end
		axil_read(`UART_ADDR_STATUS, rd);
		if (rd[1] != 1'b0) begin
			report_mismatch("parity_err (STATUS)", {31'h0, rd[1]}, 32'h0);
		end
		finish_test("injected parity error", err_before);
	endtask

	task automatic overrun_test();
		int err_before;
		logic [7:0] first_val;
		logic [7:0] second_val;
		logic [31:0] st;
		logic [31:0] seen;
		logic [31:0] rd;
		bit ok;
		err_before = errors;
		axil_write(`UART_ADDR_CTRL, CTRL_NO_PAR);
		first_val = next_byte();
		second_val = next_byte();
		axil_write(`UART_ADDR_TXDATA, {24'h0, first_val});
		wait_status(ST_RX_VALID, ST_RX_VALID, "the first byte", st, seen, ok);
		wait_status(ST_TX_BUSY, 32'h0, "transmitter idle", st, seen, ok);
		axil_write(`UART_ADDR_TXDATA, {24'h0, second_val});
		wait_status(ST_OVERRUN, ST_OVERRUN, "overrun", st, seen, ok);
		if (ok && st[0] != 1'b1) begin
			report_mismatch("rx_valid (STATUS)", {31'h0, st[0]}, 32'h1);
		end
		axil_read(`UART_ADDR_RXDATA, rd);
		if (rd != {24'h0, second_val}) begin
			report_mismatch("rdata (RXDATA)", rd, {24'h0, second_val});
		end
		axil_read(`UART_ADDR_STATUS, rd);
		if (rd[2:0] != 3'b000) begin
			report_mismatch("rdata (STATUS)", {29'h0, rd[2:0]}, 32'h0);
		end
		finish_test("overrun", err_before);
	endtask

	task automatic rx_disabled_test();
		int err_before;
		logic [31:0] st;
		logic [31:0] seen;
		bit ok;
		err_before = errors;
		wait_status(ST_TX_BUSY, 32'h0, "transmitter idle", st, seen, ok);
		axil_write(`UART_ADDR_CTRL, CTRL_TX_ONLY);
		axil_write(`UART_ADDR_TXDATA, {24'h0, next_byte()});
		wait_status(ST_TX_BUSY, ST_TX_BUSY, "transmitter start", st, seen, ok);
		if (seen[0] != 1'b0) begin
			report_mismatch("rx_valid (STATUS)", {31'h0, seen[0]}, 32'h0);
		end
		wait_status(ST_TX_BUSY, 32'h0, "end of the frame", st, seen, ok);
		if (seen[0] != 1'b0) begin
			report_mismatch("rx_valid (STATUS)", {31'h0, seen[0]}, 32'h0);
		end
		finish_test("receiver disabled", err_before);
	endtask

	initial begin
		rst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		inject = 1'b0;
		inj_bit = 1'b1;
		rng_state = 32'h9093468f;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		reset_values_test();
		loopback_test("loopback without parity", CTRL_NO_PAR);
		loopback_test("loopback with even parity", CTRL_EVEN);
		loopback_test("loopback with odd parity", CTRL_ODD);
		parity_error_test();
		overrun_test();
		rx_disabled_test();

		if (u_uart_top.u_checker.fail_count != 0) begin
			$display("%0d assertion failures in the checker", u_uart_top.u_checker.fail_count);
			errors += u_uart_top.u_checker.fail_count;
		end
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+logic
logic/uart_pkg.sv
logic/uart_baud_gen.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_axil_regs.sv
logic/uart_top.sv
testbench/uart_checker.sv
testbench/uart_tb.sv
